// File: src/vliw_defines.svh
//========================================
// VLIW datapath widths, bank layout and
// fixed-point escape limit
//========================================
`ifndef VLIW_DEFINES_SVH
`define VLIW_DEFINES_SVH

// Data word and operand address layout
`define WORD_W     27
`define ADDR_W     10
`define INDEX_W    8
`define BANK_W     2
`define NUM_BANKS  4

// Signed fixed point, 22 fraction bits
`define FRAC_W     22

// Escape limit 4.0
`define MAX_MAGNITUDE (1 << (`FRAC_W + 2))

`endif

// File: src/vliw_pkg.sv
//========================================
// Shared types of the VLIW datapath
//========================================
`default_nettype none

`include "vliw_defines.svh"

package vliw_pkg;

   typedef logic signed [`WORD_W-1:0] word_t;

   // Producer banks, in write priority order
   typedef enum logic [`BANK_W-1:0] {
      BANK_LD,
      BANK_NEG,
      BANK_ADD,
      BANK_MUL
   } bank_id_t;

   // Top bits pick the bank, low bits the word
   typedef struct packed {
      logic [`ADDR_W-`INDEX_W-1:0] bank;
      logic [`INDEX_W-1:0]         index;
   } bank_addr_t;

   typedef struct packed {
      logic       enable;
      word_t      value;
      bank_addr_t dest;
   } load_slot_t;

   typedef struct packed {
      logic       enable;
      bank_addr_t src;
      bank_addr_t dest;
   } neg_slot_t;

   // Two-operand slot, add and mul
   typedef struct packed {
      logic       enable;
      bank_addr_t src1;
      bank_addr_t src2;
      bank_addr_t dest;
   } bin_slot_t;

   typedef struct packed {
      logic       enable;
      bank_addr_t dest;
      word_t      data;
   } write_req_t;

   typedef struct packed {
      word_t z_re;
      word_t z_im;
      word_t magnitude;
   } arch_regs_t;

   typedef struct packed {
      word_t neg_a;
      word_t add_a;
      word_t add_b;
      word_t mul_a;
      word_t mul_b;
   } operands_t;

endpackage

`default_nettype wire

// File: src/operand_select.sv
//========================================
// Operand select: resolves the five source
// addresses to register or bank values
//========================================
`timescale 1ns/100ps
`default_nettype none

module operand_select import vliw_pkg::*; (
   input  wire bank_addr_t  neg_src,
   input  wire bank_addr_t  add_src1,
   input  wire bank_addr_t  add_src2,
   input  wire bank_addr_t  mul_src1,
   input  wire bank_addr_t  mul_src2,
   input  wire word_t [4:0] bank_data,
   input  wire arch_regs_t  arch_regs,
   output bank_addr_t [4:0] read_addr,
   output operands_t        operands
);

   bank_addr_t [4:0] src;
   word_t      [4:0] value;

   // Index 0, 1 and 2 of every bank alias the architectural registers
   function automatic word_t resolve(input bank_addr_t addr,
                                     input word_t      bank_word,
                                     input arch_regs_t regs);
      case (addr.index)
         0:       return regs.z_re;
         1:       return regs.z_im;
         2:       return regs.magnitude;
         default: return bank_word;
      endcase
   endfunction

   // Read port order: neg, add1, add2, mul1, mul2
   assign src = {mul_src2, mul_src1, add_src2, add_src1, neg_src};

   assign read_addr = src;

   always_comb begin
      for (int r = 0; r < 5; r++) begin
         value[r] = resolve(src[r], bank_data[r], arch_regs);
      end
   end

   assign operands = '{
      neg_a: value[0],
      add_a: value[1],
      add_b: value[2],
      mul_a: value[3],
      mul_b: value[4]
   };

endmodule

`default_nettype wire

// File: src/result_banks.sv
//========================================
// Result banks: one 256-word store per
// producer, five asynchronous read ports
//========================================
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defines.svh"

module result_banks import vliw_pkg::*; (
   input  wire                               clk,
   input  wire write_req_t [`NUM_BANKS-1:0] writes,
   input  wire bank_addr_t [4:0]            read_addr,
   output word_t [4:0]                       read_data
);

   localparam int DEPTH = 1 << `INDEX_W;

   //========================================
   // Storage
   //========================================

   word_t mem [`NUM_BANKS][DEPTH];

   // Each bank has a single writer, its own producer
   always_ff @(posedge clk) begin
      for (int b = 0; b < `NUM_BANKS; b++) begin
         if (writes[b].enable) begin
            mem[b][writes[b].dest.index] <= writes[b].data;
         end
      end
   end

   //========================================
   // Read ports
   //========================================

   // Old value is returned during the write cycle
   always_comb begin
      for (int r = 0; r < 5; r++) begin
         read_data[r] = mem[read_addr[r].bank][read_addr[r].index];
      end
   end

endmodule

`default_nettype wire

// File: src/execute_units.sv
//========================================
// Execute units: load, negate, two-cycle
// add and fixed-point multiply
//========================================
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defines.svh"

module execute_units import vliw_pkg::*; (
   input  wire                        clk,
   input  wire                        reset,
   input  wire load_slot_t            load_slot,
   input  wire neg_slot_t             neg_slot,
   input  wire bin_slot_t             add_slot,
   input  wire bin_slot_t             mul_slot,
   input  wire operands_t             operands,
   output write_req_t [`NUM_BANKS-1:0] writes
);

   // Add stage register
   logic       add_valid;
   bank_addr_t add_dest;
   word_t      add_sum;

   word_t                       neg_result;
   logic signed [2*`WORD_W-1:0] product;
   word_t                       mul_result;

   //========================================
   // Negate and multiply
   //========================================

   assign neg_result = -operands.neg_a;

   // Full product, then drop the extra fraction bits
   assign product    = operands.mul_a * operands.mul_b;
   assign mul_result = product[`FRAC_W +: `WORD_W];

   //========================================
   // Add pipeline
   //========================================

   always_ff @(posedge clk) begin
      if (reset) begin
         add_valid <= 1'b0;
      end else begin
         add_valid <= add_slot.enable;
      end
   end

   // Sum wraps on overflow
   always_ff @(posedge clk) begin
      add_dest <= add_slot.dest;
      add_sum  <= operands.add_a + operands.add_b;
   end

   //========================================
   // Bank write requests
   //========================================

   always_comb begin
      writes[BANK_LD] = '{
         enable: load_slot.enable,
         dest:   load_slot.dest,
         data:   load_slot.value
      };
      writes[BANK_NEG] = '{
         enable: neg_slot.enable,
         dest:   neg_slot.dest,
         data:   neg_result
      };
      writes[BANK_ADD] = '{
         enable: add_valid,
         dest:   add_dest,
         data:   add_sum
      };
      writes[BANK_MUL] = '{
         enable: mul_slot.enable,
         dest:   mul_slot.dest,
         data:   mul_result
      };
   end

endmodule

`default_nettype wire

// File: src/arch_state.sv
//========================================
// Architectural state: z_re, z_im and
// magnitude, with the escape check
//========================================
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defines.svh"

module arch_state import vliw_pkg::*; (
   input  wire                               clk,
   input  wire                               reset,
   input  wire write_req_t [`NUM_BANKS-1:0] writes,
   output arch_regs_t                        arch_regs,
   output logic                              done
);

   write_req_t win;
   logic       hit;

   //========================================
   // Write priority
   //========================================

   // Scan from the top so the lowest bank wins
   always_comb begin
      win = writes[BANK_LD];
      hit = 1'b0;
      for (int b = `NUM_BANKS - 1; b >= 0; b--) begin
         if (writes[b].enable && writes[b].dest.index < 3) begin
            win = writes[b];
            hit = 1'b1;
         end
      end
   end

   // Only one register changes per cycle
   always_ff @(posedge clk) begin
      if (reset || done) begin
         arch_regs <= '0;
      end else if (hit) begin
         case (win.dest.index)
            0:       arch_regs.z_re      <= win.data;
            1:       arch_regs.z_im      <= win.data;
            default: arch_regs.magnitude <= win.data;
         endcase
      end
   end

   //========================================
   // Escape check
   //========================================

   // Sticky until reset
   always_ff @(posedge clk) begin
      if (reset) begin
         done <= 1'b0;
      end else if (arch_regs.magnitude >= `MAX_MAGNITUDE) begin
         done <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: src/vliw_core.sv
//========================================
// VLIW core: four-slot fractal iteration
// datapath, top level
//========================================
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defines.svh"

module vliw_core import vliw_pkg::*; (
   input  wire             clk,
   input  wire             reset,
   input  wire load_slot_t load_slot,
   input  wire neg_slot_t  neg_slot,
   input  wire bin_slot_t  add_slot,
   input  wire bin_slot_t  mul_slot,
   output arch_regs_t      arch_regs,
   output logic            done
);

   bank_addr_t [4:0]            read_addr;
   word_t      [4:0]            bank_data;
   operands_t                   operands;
   write_req_t [`NUM_BANKS-1:0] writes;

   //========================================
   // Input side
   //========================================

   operand_select u_operand_select (
      .neg_src   (neg_slot.src),
      .add_src1  (add_slot.src1),
      .add_src2  (add_slot.src2),
      .mul_src1  (mul_slot.src1),
      .mul_src2  (mul_slot.src2),
      .bank_data (bank_data),
      .arch_regs (arch_regs),
      .read_addr (read_addr),
      .operands  (operands)
   );

   result_banks u_result_banks (
      .clk       (clk),
      .writes    (writes),
      .read_addr (read_addr),
      .read_data (bank_data)
   );

   //========================================
   // Execute
   //========================================

   execute_units u_execute_units (
      .clk       (clk),
      .reset     (reset),
      .load_slot (load_slot),
      .neg_slot  (neg_slot),
      .add_slot  (add_slot),
      .mul_slot  (mul_slot),
      .operands  (operands),
      .writes    (writes)
   );

   //========================================
   // Output side
   //========================================

   arch_state u_arch_state (
      .clk       (clk),
      .reset     (reset),
      .writes    (writes),
      .arch_regs (arch_regs),
      .done      (done)
   );

endmodule

`default_nettype wire

// File: sim/vliw_core_tb.sv
//========================================
// Testbench for the VLIW core with directed
// and random slots against a model
//========================================
`timescale 1ns/100ps
`default_nettype none

`include "vliw_defines.svh"

module vliw_core_tb import vliw_pkg::*; ();

   localparam int TIMEOUT = 20;

   logic       clk;
   logic       reset;
   load_slot_t load_slot;
   neg_slot_t  neg_slot;
   bin_slot_t  add_slot;
   bin_slot_t  mul_slot;
   arch_regs_t arch_regs;
   logic       done;

   integer seed = 32'h7bd8080a;

   // Reference model state
   word_t      m_bank [`NUM_BANKS][1 << `INDEX_W];
   arch_regs_t m_regs;
   logic       m_done;
   logic       m_add_valid;
   bank_addr_t m_add_dest;
   word_t      m_add_sum;

   vliw_core i_dut (
      .clk       (clk),
      .reset     (reset),
      .load_slot (load_slot),
      .neg_slot  (neg_slot),
      .add_slot  (add_slot),
      .mul_slot  (mul_slot),
      .arch_regs (arch_regs),
      .done      (done)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //========================================
   // Helpers
   //========================================

   task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
      $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch on %s", name);
   endtask

   task automatic timeout(input string what);
      $display("Timeout at %0t: %s", $time, what);
      $display("*** FAILED ***");
      $fatal(1, "wait timed out");
   endtask

   task automatic expect_word(input string name, input word_t exp, input word_t got);
      assert (got === exp) else mismatch(name, exp, got);
   endtask

   function automatic bank_addr_t addr(input int bank, input int index);
      return '{bank: bank[1:0], index: index[7:0]};
   endfunction

   function automatic load_slot_t load_op(input word_t value, input bank_addr_t dest);
      return '{enable: 1'b1, value: value, dest: dest};
   endfunction

   function automatic neg_slot_t neg_op(input bank_addr_t src, input bank_addr_t dest);
      return '{enable: 1'b1, src: src, dest: dest};
   endfunction

   function automatic bin_slot_t bin_op(input bank_addr_t a, input bank_addr_t b,
                                        input bank_addr_t dest);
      return '{enable: 1'b1, src1: a, src2: b, dest: dest};
   endfunction

   // Product scaled back by the fraction width and truncated
   function automatic word_t fx_mul(input word_t a, input word_t b);
      logic signed [2*`WORD_W-1:0] full;
      full = a * b;
      full = full >>> `FRAC_W;
      return full[`WORD_W-1:0];
   endfunction

   // Within +-2.0
   function automatic word_t rand_small();
      return $random(seed) % (1 << 23);
   endfunction

   // Only aliased or already written words
   function automatic bank_addr_t rand_src();
      int pick;
      pick = $unsigned($random(seed)) % 5;
      case (pick)
         0, 1, 2: return addr($unsigned($random(seed)) % 4, pick);
         3:       return addr(BANK_LD, 5 + $unsigned($random(seed)) % 2);
         default: return addr(BANK_ADD, 7);
      endcase
   endfunction

   // Index 0, 1, 3 or 4 so magnitude stays untouched
   function automatic bank_addr_t rand_dest();
      int idx;
      idx = $unsigned($random(seed)) % 4;
      if (idx >= 2) begin
         idx = idx + 1;
      end
      return addr($unsigned($random(seed)) % 4, idx);
   endfunction

   task automatic drive(input load_slot_t l, input neg_slot_t n, input bin_slot_t a,
                        input bin_slot_t m);
      @(posedge clk);
      load_slot <= l;
      neg_slot  <= n;
      add_slot  <= a;
      mul_slot  <= m;
   endtask

   // One cycle of instructions followed by idle slots
   task automatic issue(input load_slot_t l, input neg_slot_t n, input bin_slot_t a,
                        input bin_slot_t m);
      drive(l, n, a, m);
      drive('0, '0, '0, '0);
   endtask

   //========================================
   // Reference model
   //========================================

   function automatic word_t ref_read(input bank_addr_t a);
      if (a.index == 0) begin
         return m_regs.z_re;
      end
      if (a.index == 1) begin
         return m_regs.z_im;
      end
      if (a.index == 2) begin
         return m_regs.magnitude;
      end
      return m_bank[a.bank][a.index];
   endfunction

   always @(posedge clk) begin : ref_model
      write_req_t req [`NUM_BANKS];
      int         win;
      win = -1;
      if (reset) begin
         m_regs      <= '0;
         m_done      <= 1'b0;
         m_add_valid <= 1'b0;
      end else begin
         req[BANK_LD]  = '{enable: load_slot.enable, dest: load_slot.dest,
                           data: load_slot.value};
         req[BANK_NEG] = '{enable: neg_slot.enable, dest: neg_slot.dest,
                           data: -ref_read(neg_slot.src)};
         req[BANK_ADD] = '{enable: m_add_valid, dest: m_add_dest, data: m_add_sum};
         req[BANK_MUL] = '{enable: mul_slot.enable, dest: mul_slot.dest,
                           data: fx_mul(ref_read(mul_slot.src1), ref_read(mul_slot.src2))};
         for (int b = 0; b < `NUM_BANKS; b++) begin
            if (req[b].enable) begin
               m_bank[b][req[b].dest.index] <= req[b].data;
               if (win < 0 && req[b].dest.index <= 2) begin
                  win = b;
               end
            end
         end
         m_add_valid <= add_slot.enable;
         m_add_dest  <= add_slot.dest;
         m_add_sum   <= ref_read(add_slot.src1) + ref_read(add_slot.src2);
         if (m_done) begin
            m_regs <= '0;
         end else if (win >= 0) begin
            case (req[win].dest.index)
               0:       m_regs.z_re      <= req[win].data;
               1:       m_regs.z_im      <= req[win].data;
               default: m_regs.magnitude <= req[win].data;
            endcase
         end
         m_done <= m_done || (m_regs.magnitude >= `MAX_MAGNITUDE);
      end
   end

   // Outputs are stable at the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         assert (done === m_done) else mismatch("done", m_done, done);
         expect_word("z_re", m_regs.z_re, arch_regs.z_re);
         expect_word("z_im", m_regs.z_im, arch_regs.z_im);
         expect_word("magnitude", m_regs.magnitude, arch_regs.magnitude);
      end
   end

   //========================================
   // Stimulus
   //========================================

   initial begin : stimulus
      word_t x;
      word_t y;
      word_t v0;
      word_t v1;
      int    waited;
      load_slot <= '0;
      neg_slot  <= '0;
      add_slot  <= '0;
      mul_slot  <= '0;
      reset     <= 1'b1;
      x  = rand_small();
      y  = rand_small();
      v0 = rand_small();
      v1 = rand_small();
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      assert (done === 1'b0) else mismatch("done", 0, done);
      expect_word("z_re", '0, arch_regs.z_re);
      expect_word("z_im", '0, arch_regs.z_im);
      expect_word("magnitude", '0, arch_regs.magnitude);

      // Loads into aliased and plain bank words
      issue(load_op(v0, addr(BANK_LD, 0)), '0, '0, '0);
      @(negedge clk);
      expect_word("z_re", v0, arch_regs.z_re);
      issue(load_op(v1, bank_addr_t'(10'd769)), '0, '0, '0);
      @(negedge clk);
      expect_word("z_im", v1, arch_regs.z_im);
      issue(load_op(x, addr(BANK_LD, 5)), '0, '0, '0);
      issue(load_op(y, addr(BANK_LD, 6)), '0, '0, '0);
      @(negedge clk);
      expect_word("z_re", v0, arch_regs.z_re);
      expect_word("z_im", v1, arch_regs.z_im);

      // Multiply then negate
      issue('0, '0, '0, bin_op(addr(BANK_LD, 5), addr(BANK_LD, 6), addr(BANK_MUL, 1)));
      @(negedge clk);
      expect_word("z_im", fx_mul(x, y), arch_regs.z_im);
      issue('0, neg_op(addr(BANK_LD, 5), addr(BANK_NEG, 0)), '0, '0);
      @(negedge clk);
      expect_word("z_re", -x, arch_regs.z_re);

      // Back-to-back adds where the last one reads bank add
      issue('0, '0, bin_op(addr(BANK_LD, 5), addr(BANK_LD, 6), addr(BANK_ADD, 7)), '0);
      drive('0, '0, bin_op(addr(BANK_LD, 5), addr(BANK_LD, 6), addr(BANK_ADD, 0)), '0);
      drive('0, '0, bin_op(addr(BANK_ADD, 7), addr(BANK_LD, 5), addr(BANK_ADD, 1)), '0);
      @(negedge clk);
      expect_word("z_re", -x, arch_regs.z_re);
      drive('0, '0, '0, '0);
      @(negedge clk);
      expect_word("z_re", x + y, arch_regs.z_re);
      expect_word("z_im", fx_mul(x, y), arch_regs.z_im);
      @(negedge clk);
      expect_word("z_im", x + y + x, arch_regs.z_im);

      // Load beats mul on the same register
      issue(load_op(v1, addr(BANK_LD, 0)), '0, '0,
            bin_op(addr(BANK_LD, 5), addr(BANK_LD, 6), addr(BANK_MUL, 0)));
      @(negedge clk);
      expect_word("z_re", v1, arch_regs.z_re);

      repeat (60) begin
         drive('{enable: $random(seed), value: rand_small(), dest: rand_dest()},
               '{enable: $random(seed), src: rand_src(), dest: rand_dest()},
               '{enable: $random(seed), src1: rand_src(), src2: rand_src(), dest: rand_dest()},
               '{enable: $random(seed), src1: rand_src(), src2: rand_src(), dest: rand_dest()});
      end
      drive('0, '0, '0, '0);
      repeat (3) @(negedge clk);

      // Escape check
      issue(load_op(`MAX_MAGNITUDE - 1, addr(BANK_LD, 2)), '0, '0, '0);
      repeat (4) begin
         @(negedge clk);
         assert (done === 1'b0) else mismatch("done", 0, done);
      end
      issue(load_op(`MAX_MAGNITUDE, addr(BANK_LD, 2)), '0, '0, '0);
      waited = 0;
      @(negedge clk);
      while (done !== 1'b1) begin
         waited++;
         if (waited > TIMEOUT) begin
            timeout("done never rose after magnitude reached 4.0");
         end
         @(negedge clk);
      end
      assert (waited == 1) else mismatch("done latency", 1, waited);
      @(negedge clk);
      expect_word("z_re", '0, arch_regs.z_re);
      expect_word("magnitude", '0, arch_regs.magnitude);
      issue(load_op(v0, addr(BANK_LD, 0)), '0, '0, '0);
      repeat (3) begin
         @(negedge clk);
         assert (done === 1'b1) else mismatch("done", 1, done);
         expect_word("z_re", '0, arch_regs.z_re);
      end

      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: vliw_core.f
+incdir+src
src/vliw_pkg.sv
src/operand_select.sv
src/result_banks.sv
src/execute_units.sv
src/arch_state.sv
src/vliw_core.sv
sim/vliw_core_tb.sv
